// File: tests/icache_vectors.txt
// Columns are op, fetch address, expected parcel, expected request count
// Op 0 is a fetch, 1 a flush, 2 a fetch with parcel_ready held low, ff ends the list
// Cold miss, then the rest of the block back to back
0 00001004 effb1004 00000001
0 00001000 efff1000 00000001
0 0000100c eff3100c 00000001
0 00001008 eff71008 00000001
// Three blocks in set 2, FIFO victim order
0 00002020 dfdf2020 00000002
0 00003024 cfdb3024 00000003
0 00004028 bfd74028 00000004
0 0000302c cfd3302c 00000004
0 00002020 dfdf2020 00000005
0 00004020 bfdf4020 00000005
// Flush drops cached blocks
0 00001004 effb1004 00000005
1 00000000 00000000 00000005
0 00001004 effb1004 00000006
0 00004020 bfdf4020 00000007
// Back-pressure on a hit and on a miss
2 00004024 bfdb4024 00000007
0 00001008 eff71008 00000007
2 00005044 afbb5044 00000008
0 00005040 afbf5040 00000008
ff 00000000 00000000 00000000

// File: project.f
src/icache_pkg.sv
src/icache_fill_if.sv
src/icache_fetch_stage.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_refill_ctrl.sv
src/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// File: tests/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int          MAX_VEC  = 64;
  localparam logic [31:0] OP_FETCH = 32'h0;
  localparam logic [31:0] OP_FLUSH = 32'h1;
  localparam logic [31:0] OP_STALL = 32'h2;   // Fetch with parcel_ready held low
  localparam logic [31:0] OP_END   = 32'hff;

  logic        clk;
  logic        rstn;
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  logic        parcel_ready;
  logic        flush_req;
  wire         fetch_ready;
  wire         parcel_valid;
  wire  [31:0] parcel_pc;
  wire  [31:0] parcel;
  wire         mem_req;
  wire  [31:0] mem_addr;
  wire         mem_ack;
  wire         mem_rvalid;
  wire  [31:0] mem_rdata;
  wire  [31:0] req_count;

  logic [31:0] vec_mem [0:4*MAX_VEC-1];   // op, addr, parcel, count per line
  int          num_vec;
  int          cycle = 0;
  int          cycle_limit = 0;
  int          last_acc_cycle = 0;       // Cycle after the latest accept
  bit          prev_hit = 1'b0;          // Latest fetch was a plain hit
  logic [31:0] prev_count = '0;          // Expected count of the last vector

  // Outstanding fetches, oldest first
  logic [31:0] exp_pc_q[$];
  logic [31:0] exp_parcel_q[$];
  logic [31:0] exp_count_q[$];
  int          exp_cycle_q[$];           // -1 when latency is not fixed
  int          exp_vec_q[$];
  logic [31:0] m_pc, m_parcel, m_count;
  int          m_cycle, m_vec;

  icache_top dut0 (
    .clk(clk), .rstn(rstn),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_ready(fetch_ready),
    .parcel_valid(parcel_valid), .parcel_pc(parcel_pc), .parcel(parcel),
    .parcel_ready(parcel_ready), .flush_req(flush_req),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
  );

  icache_mem_model mem0 (
    .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_ack(mem_ack), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .req_count(req_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Wait until every accepted fetch has been delivered
  task automatic drain_parcels();
    while (exp_pc_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////
  // Operations
  ////////////////////
  task automatic hold_parcel(input int idx);
    logic [31:0] held_pc;
    logic [31:0] held_word;
    @(negedge clk);
    while (!parcel_valid) @(negedge clk);
    held_pc   = parcel_pc;
    held_word = parcel;
    repeat (3) begin                               // Back-pressure window
      @(negedge clk);
      check_value($sformatf("vec %0d held valid", idx), 1, parcel_valid);
      check_value($sformatf("vec %0d held pc", idx), held_pc, parcel_pc);
      check_value($sformatf("vec %0d held parcel", idx), held_word, parcel);
      check_value($sformatf("vec %0d fetch_ready low", idx), 0, fetch_ready);
    end
    @(posedge clk);
    #1;
    parcel_ready = 1'b1;
    drain_parcels();
    @(negedge clk);                                // No second copy
    check_value($sformatf("vec %0d single delivery", idx), 0, parcel_valid);
    @(posedge clk);
    #1;
  endtask

  task automatic issue_fetch(input int idx, input bit stall);
    logic [31:0] exp_cnt;
    bit          accepted;
    bit          is_hit;
    exp_cnt  = vec_mem[4*idx+3];
    accepted = 1'b0;
    is_hit   = (exp_cnt == prev_count) && !stall;  // No new request means a hit
    if (stall) begin
      fetch_valid = 1'b0;                          // Old address must not go in again
      drain_parcels();
      parcel_ready = 1'b0;
    end
    fetch_valid = 1'b1;
    fetch_pc    = vec_mem[4*idx+1];
    while (!accepted) begin
      @(negedge clk);
      accepted = fetch_ready;                      // Handshake on the next edge
      @(posedge clk);
      #1;
    end
    // Two hits in a row go in on consecutive edges
    if (is_hit && prev_hit) begin
      check_value($sformatf("vec %0d back-to-back accept", idx), last_acc_cycle + 1, cycle);
    end
    last_acc_cycle = cycle;
    prev_hit       = is_hit;
    exp_pc_q.push_back(vec_mem[4*idx+1]);
    exp_parcel_q.push_back(vec_mem[4*idx+2]);
    exp_count_q.push_back(exp_cnt);
    exp_vec_q.push_back(idx);
    exp_cycle_q.push_back(is_hit ? cycle : -1);    // Hit parcel due in this very cycle
    prev_count = exp_cnt;
    if (stall) begin
      fetch_valid = 1'b0;
      hold_parcel(idx);
    end
  endtask

  task automatic send_flush(input int idx);
    fetch_valid = 1'b0;
    drain_parcels();
    check_value($sformatf("vec %0d count before flush", idx), vec_mem[4*idx+3], req_count);
    prev_count = vec_mem[4*idx+3];
    prev_hit   = 1'b0;
    flush_req  = 1'b1;                             // One cycle pulse
    @(posedge clk);
    #1;
    flush_req  = 1'b0;
  endtask

  ////////////////////
  // Parcel monitor
  ////////////////////
  always @(negedge clk) begin
    if (rstn && parcel_valid && parcel_ready) begin
      if (exp_pc_q.size() == 0) begin
        stop_run("Parcel delivered while no fetch was outstanding");
      end else begin
        m_pc     = exp_pc_q.pop_front();
        m_parcel = exp_parcel_q.pop_front();
        m_count  = exp_count_q.pop_front();
        m_cycle  = exp_cycle_q.pop_front();
        m_vec    = exp_vec_q.pop_front();
        check_value($sformatf("vec %0d parcel_pc", m_vec), m_pc, parcel_pc);
        check_value($sformatf("vec %0d parcel", m_vec), m_parcel, parcel);
        check_value($sformatf("vec %0d request count", m_vec), m_count, req_count);
        if (m_cycle >= 0) begin
          check_value($sformatf("vec %0d hit cycle", m_vec), m_cycle, cycle);
        end
      end
    end
    // Burst address is the block of the held miss
    if (rstn && mem_req) begin
      if (exp_pc_q.size() == 0) begin
        stop_run("Memory request raised while no fetch was outstanding");
      end else begin
        check_value($sformatf("vec %0d mem_addr", exp_vec_q[0]),
                    exp_pc_q[0] & ~32'hf, mem_addr);
      end
    end
  end

  // Cycle count and watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      stop_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    rstn         = 1'b0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    parcel_ready = 1'b1;
    flush_req    = 1'b0;
    num_vec      = 0;
    $readmemh("tests/icache_vectors.txt", vec_mem);
    while (num_vec < MAX_VEC && !$isunknown(vec_mem[4*num_vec]) &&
           vec_mem[4*num_vec] != OP_END) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      stop_run("No vectors could be read from tests/icache_vectors.txt");
    end
    cycle_limit = 20 * num_vec + 100;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("reset parcel_valid", 0, parcel_valid);
    check_value("reset mem_req", 0, mem_req);
    check_value("reset fetch_ready", 0, fetch_ready);
    @(posedge clk);                                // Fifth reset cycle
    #1;
    rstn = 1'b1;
    for (int i = 0; i < num_vec; i++) begin
      case (vec_mem[4*i])
        OP_FETCH: issue_fetch(i, 1'b0);
        OP_STALL: issue_fetch(i, 1'b1);
        OP_FLUSH: send_flush(i);
        default:  stop_run($sformatf("Unknown operation %h in vector %0d", vec_mem[4*i], i));
      endcase
    end
    fetch_valid = 1'b0;
    drain_parcels();
    check_value("final request count", prev_count, req_count);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
  input  wire                          clk,
  input  wire                          rstn,
  input  wire                          mem_req,
  input  wire  [icache_pkg::XLEN-1:0]  mem_addr,
  output logic                         mem_ack,
  output logic                         mem_rvalid,
  output logic [icache_pkg::XLEN-1:0]  mem_rdata,
  output logic [31:0]                  req_count     // Bursts started so far
);

  logic [icache_pkg::XLEN-1:0] base;     // Block address of current burst
  logic [31:0]                 rng_seed;
  logic [31:0]                 rnd;
  logic                        gap;      // Idle cycle after beat 1

  // Low address half, upper half inverted
  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {~a[15:0], a[15:0]};
  endfunction

  ////////////////////
  // Responder
  ////////////////////
  initial begin
    mem_ack    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    req_count  = '0;
    rng_seed   = 32'hf1a2947b;
    rnd        = $urandom(rng_seed);        // Seed once for the run
    forever begin
      @(posedge clk);
      #1;                                   // Same offset as the CPU side drive
      if (rstn && mem_req) begin
        base      = mem_addr;
        req_count = req_count + 1;
        rnd       = $urandom;
        gap       = rnd[0];
        repeat (2) begin                    // Ack two cycles after the request
          @(posedge clk);
          #1;
        end
        mem_ack = 1'b1;
        @(posedge clk);
        #1;
        mem_ack = 1'b0;
        for (int b = 0; b < icache_pkg::BLOCK_WORDS; b++) begin
          mem_rvalid = 1'b1;
          mem_rdata  = word_at(base + 32'(4 * b));   // Words 0..3 in order
          @(posedge clk);
          #1;
          mem_rvalid = 1'b0;
          if (b == 1 && gap) begin
            @(posedge clk);                 // Bubble in the middle of the burst
            #1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire                           clk,
  input  wire                           rstn,

  // CPU side
  input  wire                           fetch_valid,
  input  wire [icache_pkg::XLEN-1:0]    fetch_pc,
  output wire                           fetch_ready,
  output wire                           parcel_valid,
  output wire [icache_pkg::XLEN-1:0]    parcel_pc,
  output wire [icache_pkg::XLEN-1:0]    parcel,
  input  wire                           parcel_ready,
  input  wire                           flush_req,    // Single-cycle pulse

  // Memory side
  output wire                           mem_req,
  output wire [icache_pkg::XLEN-1:0]    mem_addr,
  input  wire                           mem_ack,
  input  wire                           mem_rvalid,
  input  wire [icache_pkg::XLEN-1:0]    mem_rdata
);

  wire                                 lookup_valid;  // Stage 2 holds an address
  wire [icache_pkg::XLEN-1:0]          lookup_pc;
  wire [icache_pkg::IDX_BITS-1:0]      rd_idx;        // Array read address
  wire [icache_pkg::WORD_BITS-1:0]     rd_word;
  wire [icache_pkg::WAYS-1:0]          hit_way;       // One-hot, or zero on miss
  wire                                 victim_way;
  wire                                 busy;          // Flush or fill running

  icache_fill_if fill_bus ();

  ////////////////////
  // Stage 1
  ////////////////////
  icache_fetch_stage u_fetch (
    .clk          (clk),
    .rstn         (rstn),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .parcel_ready (parcel_ready),
    .hit          (|hit_way),
    .busy         (busy),
    .fetch_ready  (fetch_ready),
    .lookup_valid (lookup_valid),
    .lookup_pc    (lookup_pc),
    .rd_idx       (rd_idx),
    .rd_word      (rd_word)
  );

  ////////////////////
  // Arrays
  ////////////////////
  icache_tag_array u_tags (
    .clk        (clk),
    .rstn       (rstn),
    .rd_idx     (rd_idx),
    .lookup_pc  (lookup_pc),
    .fill       (fill_bus.array),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  icache_data_array u_data (
    .clk        (clk),
    .rd_idx     (rd_idx),
    .rd_word    (rd_word),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .fill       (fill_bus.array),
    .parcel     (parcel)
  );

  ////////////////////
  // Refill and flush
  ////////////////////
  icache_refill_ctrl u_refill (
    .clk          (clk),
    .rstn         (rstn),
    .flush_req    (flush_req),
    .lookup_valid (lookup_valid),
    .lookup_pc    (lookup_pc),
    .hit_way      (hit_way),
    .mem_ack      (mem_ack),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .busy         (busy),
    .parcel_valid (parcel_valid),
    .parcel_pc    (parcel_pc),
    .fill         (fill_bus.ctrl)
  );

endmodule

`default_nettype wire

// File: src/icache_refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl (
  input  wire                                clk,
  input  wire                                rstn,
  input  wire                                flush_req,
  input  wire                                lookup_valid,
  input  wire [icache_pkg::XLEN-1:0]         lookup_pc,
  input  wire [icache_pkg::WAYS-1:0]         hit_way,
  input  wire                                mem_ack,
  input  wire                                mem_rvalid,
  input  wire [icache_pkg::XLEN-1:0]         mem_rdata,
  output logic                               mem_req,
  output logic [icache_pkg::XLEN-1:0]        mem_addr,
  output logic                               busy,
  output logic                               parcel_valid,
  output logic [icache_pkg::XLEN-1:0]        parcel_pc,
  icache_fill_if.ctrl                        fill
);

  logic [1:0]                         state;
  logic [icache_pkg::IDX_BITS-1:0]    sweep_cnt;    // Set being invalidated
  logic [icache_pkg::WORD_BITS-1:0]   beat_cnt;     // Word of the incoming beat
  logic                               flush_pend;   // Flush seen outside ARMED
  logic                               reread;       // Idle cycle after last beat
  logic                               flush_go;
  logic                               miss;
  logic                               beat_we;
  logic                               last_beat;
  logic [icache_pkg::IDX_BITS-1:0]    miss_idx;

  assign miss_idx  = lookup_pc[icache_pkg::IDX_LSB +: icache_pkg::IDX_BITS];
  assign flush_go  = flush_req | flush_pend;
  assign miss      = lookup_valid & ~(|hit_way);
  assign beat_we   = (state == icache_pkg::ST_FILL) & mem_rvalid & ~reread;
  assign last_beat = beat_we & (&beat_cnt);          // Word BLOCK_WORDS-1

  ////////////////////
  // Main FSM
  ////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= icache_pkg::ST_FLUSH;                 // Sweep right out of reset
    end else begin
      case (state)
        icache_pkg::ST_FLUSH: if (&sweep_cnt) state <= icache_pkg::ST_ARMED;
        icache_pkg::ST_ARMED: begin
          if (flush_go) begin
            state <= icache_pkg::ST_FLUSH;           // Flush wins over a miss
          end else if (miss) begin
            state <= icache_pkg::ST_FILL;
          end
        end
        icache_pkg::ST_FILL:  if (reread) state <= icache_pkg::ST_ARMED;
        default:              state <= icache_pkg::ST_FLUSH;
      endcase
    end
  end

  // Counters, both wrap back to zero on their own
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sweep_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      if (state == icache_pkg::ST_FLUSH) sweep_cnt <= sweep_cnt + 1'b1;
      if (beat_we) beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flush_pend <= 1'b0;
      reread     <= 1'b0;
      mem_req    <= 1'b0;
    end else begin
      flush_pend <= flush_go & (state != icache_pkg::ST_ARMED);  // Kept until ARMED
      reread     <= last_beat;                       // Arrays re-read held index
      if ((state == icache_pkg::ST_ARMED) & ~flush_go & miss) begin
        mem_req <= 1'b1;                             // High in first FILL cycle
      end else if (mem_ack) begin
        mem_req <= 1'b0;
      end
    end
  end

  // Block aligned, stable while the lookup is held
  assign mem_addr = {lookup_pc[icache_pkg::XLEN-1:icache_pkg::IDX_LSB],
                     {icache_pkg::IDX_LSB{1'b0}}};

  ////////////////////
  // Array writes
  ////////////////////
  assign fill.data_we   = beat_we;
  assign fill.data_idx  = miss_idx;
  assign fill.data_word = beat_cnt;
  assign fill.wdata     = mem_rdata;
  assign fill.tag_we    = last_beat;                 // With the last data word
  assign fill.tag_idx   = (state == icache_pkg::ST_FLUSH) ? sweep_cnt : miss_idx;
  assign fill.tag       = lookup_pc[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS];
  assign fill.inval     = (state == icache_pkg::ST_FLUSH);

  // CPU side status
  assign busy         = (state != icache_pkg::ST_ARMED);
  assign parcel_valid = lookup_valid & (|hit_way) & (state != icache_pkg::ST_FLUSH);
  assign parcel_pc    = lookup_pc;

endmodule

`default_nettype wire

// File: src/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array (
  input  wire                                clk,
  input  wire [icache_pkg::IDX_BITS-1:0]     rd_idx,
  input  wire [icache_pkg::WORD_BITS-1:0]    rd_word,
  input  wire [icache_pkg::WAYS-1:0]         hit_way,     // One-hot select
  input  wire                                victim_way,
  icache_fill_if.array                       fill,
  output logic [icache_pkg::XLEN-1:0]        parcel
);

  // Word storage, addressed by {set, word}
  logic [icache_pkg::XLEN-1:0] mem
    [icache_pkg::WAYS][icache_pkg::SETS*icache_pkg::BLOCK_WORDS];
  logic [icache_pkg::XLEN-1:0] rd_data [icache_pkg::WAYS];

  ////////////////////
  // Beat write
  ////////////////////
  always_ff @(posedge clk) begin
    if (fill.data_we) begin
      mem[victim_way][{fill.data_idx, fill.data_word}] <= fill.wdata;
    end
  end

  // Both ways read every cycle
  always_ff @(posedge clk) begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      rd_data[w] <= mem[w][{rd_idx, rd_word}];
    end
  end

  // AND-OR mux, zero when nothing hits
  always_comb begin
    parcel = '0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      parcel = parcel | (rd_data[w] & {icache_pkg::XLEN{hit_way[w]}});
    end
  end

endmodule

`default_nettype wire

// File: src/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
  input  wire                                clk,
  input  wire                                rstn,
  input  wire [icache_pkg::IDX_BITS-1:0]     rd_idx,
  input  wire [icache_pkg::XLEN-1:0]         lookup_pc,
  icache_fill_if.array                       fill,
  output logic [icache_pkg::WAYS-1:0]        hit_way,
  output logic                               victim_way
);

  // Storage, tags carry no reset
  logic [icache_pkg::TAG_BITS-1:0] tag_mem [icache_pkg::WAYS][icache_pkg::SETS];
  logic [icache_pkg::SETS-1:0]     valid_q [icache_pkg::WAYS];
  logic [icache_pkg::SETS-1:0]     fifo_ptr;           // Next way to replace, per set

  // Read port registers
  logic [icache_pkg::TAG_BITS-1:0] rd_tag  [icache_pkg::WAYS];
  logic [icache_pkg::WAYS-1:0]     rd_valid;
  logic                            inval_rd;           // Sweep hits the set being read
  logic [icache_pkg::TAG_BITS-1:0] pc_tag;

  assign pc_tag     = lookup_pc[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS];
  assign victim_way = fifo_ptr[fill.tag_idx];          // Stable for a whole fill
  assign inval_rd   = fill.inval & (fill.tag_idx == rd_idx);

  ////////////////////
  // Valid bits and FIFO pointers
  ////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        valid_q[w] <= '0;
      end
      fifo_ptr <= '0;
    end else if (fill.inval) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        valid_q[w][fill.tag_idx] <= 1'b0;
      end
      fifo_ptr[fill.tag_idx] <= 1'b0;                  // Refill starts at way 0
    end else if (fill.tag_we) begin
      valid_q[victim_way][fill.tag_idx] <= 1'b1;
      fifo_ptr[fill.tag_idx]            <= ~victim_way; // Round robin of two
    end
  end

  ////////////////////
  // Tag storage
  ////////////////////
  always_ff @(posedge clk) begin
    if (fill.tag_we) begin
      tag_mem[victim_way][fill.tag_idx] <= fill.tag;
    end
  end

  // Synchronous read, tag part
  always_ff @(posedge clk) begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      rd_tag[w] <= tag_mem[w][rd_idx];
    end
  end

  // Valid read is write-first for invalidation, so the last swept set
  // cannot show a stale hit right after a flush
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_valid <= '0;
    end else begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        rd_valid[w] <= valid_q[w][rd_idx] & ~inval_rd;
      end
    end
  end

  // Compare both ways against the held lookup
  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      hit_way[w] = rd_valid[w] & (rd_tag[w] == pc_tag);
    end
  end

endmodule

`default_nettype wire

// File: src/icache_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_stage (
  input  wire                                clk,
  input  wire                                rstn,
  input  wire                                fetch_valid,
  input  wire [icache_pkg::XLEN-1:0]         fetch_pc,
  input  wire                                parcel_ready,
  input  wire                                hit,          // Any way hit on held lookup
  input  wire                                busy,         // Flush or fill in progress
  output logic                               fetch_ready,
  output logic                               lookup_valid,
  output logic [icache_pkg::XLEN-1:0]        lookup_pc,
  output logic [icache_pkg::IDX_BITS-1:0]    rd_idx,
  output logic [icache_pkg::WORD_BITS-1:0]   rd_word
);

  logic accept;   // Fetch handshake this cycle
  logic taken;    // Held lookup delivered to CPU

  // Lookup leaves only as a valid parcel, never during flush/fill
  assign taken = lookup_valid & hit & parcel_ready & ~busy;

  // Slot free, or freed on this same edge
  assign fetch_ready = ~busy & (~lookup_valid | (hit & parcel_ready));
  assign accept      = fetch_valid & fetch_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lookup_valid <= 1'b0;
    end else if (accept) begin
      lookup_valid <= 1'b1;             // Back to back when taken
    end else if (taken) begin
      lookup_valid <= 1'b0;
    end
  end

  // Held while missing or back-pressured
  always_ff @(posedge clk) begin
    if (accept) begin
      lookup_pc <= fetch_pc;
    end
  end

  // Read the incoming address, else keep re-reading the held one
  always_comb begin
    if (accept) begin
      rd_idx  = fetch_pc[icache_pkg::IDX_LSB +: icache_pkg::IDX_BITS];
      rd_word = fetch_pc[icache_pkg::OFF_LSB +: icache_pkg::WORD_BITS];
    end else begin
      rd_idx  = lookup_pc[icache_pkg::IDX_LSB +: icache_pkg::IDX_BITS];
      rd_word = lookup_pc[icache_pkg::OFF_LSB +: icache_pkg::WORD_BITS];
    end
  end

endmodule

`default_nettype wire

// File: src/icache_fill_if.sv
`timescale 1ns/1ps
`default_nettype none

// Array write port, refill controller to tag and data arrays
interface icache_fill_if;

  // Data array side, one word per beat
  logic                              data_we;
  logic [icache_pkg::IDX_BITS-1:0]   data_idx;
  logic [icache_pkg::WORD_BITS-1:0]  data_word;
  logic [icache_pkg::XLEN-1:0]       wdata;

  // Tag array side
  logic                              tag_we;    // Also advances FIFO pointer
  logic [icache_pkg::IDX_BITS-1:0]   tag_idx;
  logic [icache_pkg::TAG_BITS-1:0]   tag;
  logic                              inval;     // Clears whole set

  modport ctrl (
    output data_we, data_idx, data_word, wdata,
    output tag_we, tag_idx, tag, inval
  );

  modport array (
    input  data_we, data_idx, data_word, wdata,
    input  tag_we, tag_idx, tag, inval
  );

endinterface

`default_nettype wire

// File: src/icache_pkg.sv
`default_nettype none

package icache_pkg;

  //////////////////////
  // Datapath
  //////////////////////
  localparam int XLEN        = 32;        // Address and instruction word width

  //////////////////////
  // Cache geometry
  //////////////////////
  localparam int WAYS        = 2;         // Fixed two-way set associative
  localparam int SETS        = 16;
  localparam int IDX_BITS    = 4;         // log2(SETS)
  localparam int BLOCK_WORDS = 4;         // Words per block, also burst length
  localparam int WORD_BITS   = 2;         // log2(BLOCK_WORDS)
  localparam int OFF_LSB     = 2;         // Byte offset inside a word

  // Tag is whatever is left above index and offsets
  localparam int TAG_BITS    = XLEN - IDX_BITS - WORD_BITS - OFF_LSB;

  // Field positions in a fetch address
  localparam int IDX_LSB     = OFF_LSB + WORD_BITS;   // Bits 7..4
  localparam int TAG_LSB     = IDX_LSB + IDX_BITS;    // Bits 31..8

  //////////////////////
  // Refill FSM states
  //////////////////////
  localparam logic [1:0] ST_FLUSH = 2'd0;  // Invalidation sweep
  localparam logic [1:0] ST_ARMED = 2'd1;  // Normal lookups
  localparam logic [1:0] ST_FILL  = 2'd2;  // Block burst in progress

endpackage

`default_nettype wire
